// ==== all.f ====
design/ooo_pkg.sv
design/dispatch_if.sv
design/issue_control.sv
design/rob_pointers.sv
design/register_alias_table.sv
design/alu_station.sv
design/cdb_arbiter.sv
design/reorder_buffer.sv
design/ooo_core.sv
verification/ooo_core_tb.sv

// ==== verification/ooo_core_tb.sv ====
// ooo core testbench: random instruction stream checked against an in-order model
`default_nettype none

module ooo_core_tb import ooo_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_INSTR = 200;
	// worst case per instruction plus the reset cycles
	localparam int TIMEOUT_CYCLES = N_INSTR * 40 + 16;

	logic		clk;
	logic		reset;
	logic		issue_req;
	alu_op_t	issue_op;
	reg_idx_t	issue_rd;
	reg_idx_t	issue_rs1;
	reg_idx_t	issue_rs2;
	data_t		issue_imm;
	logic		issue_ack;
	logic		commit_valid;
	reg_idx_t	commit_rd;
	data_t		commit_value;

	// in-order model state
	data_t		model_regs [NUM_REGS];
	reg_idx_t	expected_rd [$];
	data_t		expected_value [$];
	reg_idx_t	exp_rd;
	data_t		exp_value;

	logic [31:0]	lfsr;
	int		errors;
	int		commit_count;
	int		cycles;
	int		req_low_cycles;
	logic		seen_req;
	logic		seen_ack;

	ooo_core dut0 (
		.clk(clk),
		.reset(reset),
		.issue_req(issue_req),
		.issue_op(issue_op),
		.issue_rd(issue_rd),
		.issue_rs1(issue_rs1),
		.issue_rs2(issue_rs2),
		.issue_imm(issue_imm),
		.issue_ack(issue_ack),
		.commit_valid(commit_valid),
		.commit_rd(commit_rd),
		.commit_value(commit_value)
	);

	always #5 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit taken
	task automatic get_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// architectural meaning of each operation
	function automatic data_t model_result(alu_op_t op, data_t x, data_t y, data_t imm);
		case (op)
			OP_ADD:		return x + y;
			OP_SUB:		return x - y;
			OP_AND:		return x & y;
			OP_OR:		return x | y;
			OP_XOR:		return x ^ y;
			default:	return x + imm;
		endcase
	endfunction

	// four-phase handshake raises req, waits for ack, drops req and waits for ack low
	task automatic send_instr(alu_op_t op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2, data_t imm);
		@(posedge clk);
		issue_req <= 1'b1;
		issue_op <= op;
		issue_rd <= rd;
		issue_rs1 <= rs1;
		issue_rs2 <= rs2;
		issue_imm <= imm;
		do @(negedge clk); while (!issue_ack);
		@(posedge clk);
		issue_req <= 1'b0;
		do @(negedge clk); while (issue_ack);
	endtask

	// give up on a stuck run
	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles with %0d of %0d commits seen",
				cycles, commit_count, N_INSTR);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// handshake and commit monitor sampled mid-cycle
	always @(negedge clk) begin
		if (reset) begin
			if (issue_req) begin
				seen_req = 1'b1;
				req_low_cycles = 0;
			end else begin
				req_low_cycles++;
			end
			if (issue_ack && !seen_req) begin
				errors++;
				$display("issue_ack went high at %0t before any request", $time);
			end
			// ack may outlive req by one cycle only
			if (issue_ack && req_low_cycles >= 2) begin
				errors++;
				$display("issue_ack still high at %0t with req low for %0d cycles",
					$time, req_low_cycles);
			end
			if (issue_ack)
				seen_ack = 1'b1;
			if (commit_valid) begin
				// every commit counts, stray ones included
				commit_count++;
				if (!seen_ack) begin
					errors++;
					$display("commit at %0t before any instruction was acknowledged", $time);
				end
				if (expected_rd.size() == 0) begin
					errors++;
					$display("commit at %0t with no instruction outstanding", $time);
				end else begin
					exp_rd = expected_rd.pop_front();
					exp_value = expected_value.pop_front();
					if (commit_rd !== exp_rd) begin
						errors++;
						$display("FAILED at %0t: commit_rd expected %0d got %0d",
							$time, exp_rd, commit_rd);
					end
					if (commit_value !== exp_value) begin
						errors++;
						$display("FAILED at %0t: commit_value expected %h got %h",
							$time, exp_value, commit_value);
					end
				end
			end
		end
	end

	initial begin
		logic [31:0]	r;
		alu_op_t	op;
		reg_idx_t	rd;
		reg_idx_t	rs1;
		reg_idx_t	rs2;
		reg_idx_t	prev_rd;
		data_t		imm;
		data_t		value;

		clk = 1'b0;
		reset = 1'b0;
		issue_req = 1'b0;
		issue_op = OP_ADD;
		issue_rd = '0;
		issue_rs1 = '0;
		issue_rs2 = '0;
		issue_imm = '0;
		lfsr = 32'hf7f7;
		errors = 0;
		commit_count = 0;
		cycles = 0;
		req_low_cycles = 0;
		seen_req = 1'b0;
		seen_ack = 1'b0;
		prev_rd = '0;
		for (int k = 0; k < NUM_REGS; k++)
			model_regs[k] = '0;

		repeat (16) @(posedge clk);
		reset <= 1'b1;

		for (int i = 0; i < N_INSTR; i++) begin
			get_bits(3, r);
			op = alu_op_t'(r % 6);
			get_bits(3, r);
			rd = r[2:0];
			get_bits(3, r);
			rs1 = r[2:0];
			get_bits(3, r);
			rs2 = r[2:0];
			get_bits(16, r);
			imm = {{16{r[15]}}, r[15:0]};
			// one in four reuses the last destination
			get_bits(2, r);
			if (r[1:0] == 2'b00) begin
				get_bits(1, r);
				if (r[0])
					rs1 = prev_rd;
				else
					rs2 = prev_rd;
			end
			// chain bursts keep stations waiting on each other
			if ((i % 50) >= 35) begin
				rs1 = prev_rd;
				rs2 = prev_rd;
				if (rd == '0)
					rd = 3'd1;
			end

			value = model_result(op, model_regs[rs1], model_regs[rs2], imm);
			if (rd != '0)
				model_regs[rd] = value;
			expected_rd.push_back(rd);
			expected_value.push_back(value);
			prev_rd = rd;

			send_instr(op, rd, rs1, rs2, imm);
		end

		// wait for the expected number of commits and then watch for stray ones
		while (commit_count < N_INSTR)
			@(posedge clk);
		repeat (20) @(posedge clk);

		if (commit_count != N_INSTR) begin
			errors++;
			$display("saw %0d commits where %0d instructions were issued",
				commit_count, N_INSTR);
		end
		if (expected_rd.size() != 0) begin
			errors++;
			$display("%0d instructions were never committed", expected_rd.size());
		end

		$display("commits: %0d, errors: %0d", commit_count, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/ooo_core.sv ====
// ooo core: top level joining issue, renaming, stations, result bus and reorder buffer
`default_nettype none

module ooo_core import ooo_pkg::*; (
	input  logic		clk,
	input  logic		reset,
	input  logic		issue_req,
	input  alu_op_t		issue_op,
	input  reg_idx_t	issue_rd,
	input  reg_idx_t	issue_rs1,
	input  reg_idx_t	issue_rs2,
	input  data_t		issue_imm,
	output logic		issue_ack,
	output logic		commit_valid,
	output reg_idx_t	commit_rd,
	output data_t		commit_value
);

	logic [N_STATIONS-1:0]	station_busy;
	logic [N_STATIONS-1:0]	request;
	logic [N_STATIONS-1:0]	grant;
	cdb_t [N_STATIONS-1:0]	result;
	cdb_t			cdb;

	operand_t		operand_a;
	operand_t		operand_b;

	logic			alloc;
	logic			rob_full;
	logic			rob_empty;
	rob_tag_t		rob_head;
	rob_tag_t		rob_tail;
	rob_tag_t		commit_tag;

	dispatch_if disp ();

	issue_control issue_control (
		.clk(clk),
		.reset(reset),
		.issue_req(issue_req),
		.issue_ack(issue_ack),
		.issue_op(issue_op),
		.issue_rd(issue_rd),
		.issue_imm(issue_imm),
		.station_busy(station_busy),
		.rob_full(rob_full),
		.alloc(alloc),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.disp(disp),
		.rob_tail(rob_tail)
	);

	rob_pointers rob_pointers (
		.clk(clk),
		.reset(reset),
		.alloc(alloc),
		.commit(commit_valid),
		.head(rob_head),
		.tail(rob_tail),
		.full(rob_full),
		.empty(rob_empty)
	);

	// rd is renamed to the entry allocated in the same cycle
	register_alias_table register_alias_table (
		.clk(clk),
		.reset(reset),
		.rs1(issue_rs1),
		.rs2(issue_rs2),
		.rename_en(alloc),
		.rename_rd(issue_rd),
		.rename_tag(rob_tail),
		.cdb(cdb),
		.commit_valid(commit_valid),
		.commit_rd(commit_rd),
		.commit_tag(commit_tag),
		.commit_value(commit_value),
		.operand_a(operand_a),
		.operand_b(operand_b)
	);

	for (genvar i = 0; i < N_STATIONS; i++) begin : g_station
		alu_station alu_station (
			.clk(clk),
			.reset(reset),
			.route(disp.route[i]),
			.disp(disp),
			.cdb(cdb),
			.grant(grant[i]),
			.request(request[i]),
			.result(result[i]),
			.busy(station_busy[i])
		);
	end

	cdb_arbiter cdb_arbiter (
		.request(request),
		.result(result),
		.grant(grant),
		.cdb(cdb)
	);

	reorder_buffer reorder_buffer (
		.clk(clk),
		.reset(reset),
		.alloc(alloc),
		.tail(rob_tail),
		.head(rob_head),
		.alloc_rd(issue_rd),
		.cdb(cdb),
		.empty(rob_empty),
		.commit(commit_valid),
		.commit_rd(commit_rd),
		.commit_tag(commit_tag),
		.commit_value(commit_value)
	);

endmodule

`default_nettype wire

// ==== design/reorder_buffer.sv ====
// reorder buffer: entry storage written at issue and by the bus, committed in order
`default_nettype none

module reorder_buffer import ooo_pkg::*; (
	input  logic		clk,
	input  logic		reset,
	input  logic		alloc,
	input  rob_tag_t	tail,
	input  rob_tag_t	head,
	input  reg_idx_t	alloc_rd,
	input  cdb_t		cdb,
	input  logic		empty,
	output logic		commit,
	output reg_idx_t	commit_rd,
	output rob_tag_t	commit_tag,
	output data_t		commit_value
);

	// result has arrived for this entry
	logic		ready [ROB_SIZE];
	reg_idx_t	dest [ROB_SIZE];
	data_t		value [ROB_SIZE];

	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int e = 0; e < ROB_SIZE; e++)
				ready[e] <= 1'b0;
		end else begin
			if (alloc)
				ready[tail] <= 1'b0;
			// results land by tag, in any order
			if (cdb.valid)
				ready[cdb.tag] <= 1'b1;
			if (commit)
				ready[head] <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (alloc)
			dest[tail] <= alloc_rd;
		if (cdb.valid)
			value[cdb.tag] <= cdb.data;
	end

	// head retires the cycle after its result is written
	always_comb begin
		commit = !empty && ready[head];
		commit_rd = dest[head];
		commit_tag = head;
		commit_value = value[head];
	end

	// each entry gets exactly one result per allocation
	a_single_write: assert property (@(posedge clk) disable iff (!reset)
		cdb.valid |-> !ready[cdb.tag]);

endmodule

`default_nettype wire

// ==== design/cdb_arbiter.sv ====
// cdb arbiter: fixed-priority grant among station result buffers onto the common data bus
`default_nettype none

module cdb_arbiter import ooo_pkg::*; (
	input  logic [N_STATIONS-1:0]	request,
	input  cdb_t [N_STATIONS-1:0]	result,
	output logic [N_STATIONS-1:0]	grant,
	output cdb_t			cdb
);

	// walk from the top so the lowest requester is the one left standing
	always_comb begin
		grant = '0;
		cdb = '0;
		for (int i = N_STATIONS - 1; i >= 0; i--) begin
			if (request[i]) begin
				grant = '0;
				grant[i] = 1'b1;
				cdb = result[i];
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/alu_station.sv ====
// alu station: reservation station with its alu and a one-entry result buffer
`default_nettype none

module alu_station import ooo_pkg::*; (
	input  logic		clk,
	input  logic		reset,
	input  logic		route,
	dispatch_if.station	disp,
	input  cdb_t		cdb,
	input  logic		grant,
	output logic		request,
	output cdb_t		result,
	output logic		busy
);

	alu_op_t	op;
	operand_t	a;
	operand_t	b;
	rob_tag_t	tag;
	// result buffer
	logic		done;
	data_t		value;
	logic		fire;

	// take a pending operand off the bus when its tag shows up
	function automatic operand_t snoop(operand_t opnd, cdb_t bus);
		operand_t captured;
		captured = opnd;
		if (opnd.pending && bus.valid && (bus.tag == opnd.tag)) begin
			captured.pending = 1'b0;
			captured.value = bus.data;
		end
		return captured;
	endfunction

	function automatic data_t alu(alu_op_t fn, data_t x, data_t y);
		case (fn)
			OP_ADD,
			OP_ADDI:	return x + y;
			OP_SUB:		return x - y;
			OP_AND:		return x & y;
			OP_OR:		return x | y;
			OP_XOR:		return x ^ y;
			default:	return '0;
		endcase
	endfunction

	// execute once, as soon as both operands are in
	assign fire = busy && !done && !a.pending && !b.pending;

	always_ff @(posedge clk) begin
		if (!reset) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			if (route)
				busy <= 1'b1;
			else if (grant)
				busy <= 1'b0;
			// buffer drains in the cycle it owns the bus
			if (fire)
				done <= 1'b1;
			else if (grant)
				done <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (route) begin
			op <= disp.op;
			a <= snoop(disp.operand_a, cdb);
			b <= snoop(disp.operand_b, cdb);
			tag <= disp.dest_tag;
		end else if (busy) begin
			a <= snoop(a, cdb);
			b <= snoop(b, cdb);
		end
		if (fire)
			value <= alu(op, a.value, b.value);
	end

	assign request = done;
	assign result = '{valid: done, tag: tag, data: value};

	// issue only picks idle stations
	a_route_idle: assert property (@(posedge clk) disable iff (!reset)
		route |-> !busy);

	// arbiter grants only a full buffer
	a_grant_done: assert property (@(posedge clk) disable iff (!reset)
		grant |-> done);

endmodule

`default_nettype wire

// ==== design/register_alias_table.sv ====
// register alias table: architectural registers with rename tags and operand lookup
`default_nettype none

module register_alias_table import ooo_pkg::*; (
	input  logic		clk,
	input  logic		reset,
	input  reg_idx_t	rs1,
	input  reg_idx_t	rs2,
	input  logic		rename_en,
	input  reg_idx_t	rename_rd,
	input  rob_tag_t	rename_tag,
	input  cdb_t		cdb,
	input  logic		commit_valid,
	input  reg_idx_t	commit_rd,
	input  rob_tag_t	commit_tag,
	input  data_t		commit_value,
	output operand_t	operand_a,
	output operand_t	operand_b
);

	// committed register values
	data_t		arch [NUM_REGS];
	// register waits on an in-flight producer
	logic		pending [NUM_REGS];
	rob_tag_t	rat_tag [NUM_REGS];
	// producer already broadcast, value kept until commit
	logic		spec_ready [NUM_REGS];
	data_t		spec_value [NUM_REGS];

	logic		do_rename;

	// r0 is hardwired and never renamed
	assign do_rename = rename_en && (rename_rd != '0);

	function automatic logic bus_hit(int r);
		return pending[r] && !spec_ready[r] && cdb.valid && (cdb.tag == rat_tag[r]);
	endfunction

	function automatic operand_t lookup(reg_idx_t idx);
		operand_t opnd;
		opnd.pending = 1'b0;
		opnd.tag = rat_tag[idx];
		opnd.value = arch[idx];
		if (idx == '0)
			opnd.value = '0;
		else if (pending[idx] && spec_ready[idx])
			opnd.value = spec_value[idx];
		// same-cycle forward from the bus
		else if (bus_hit(idx))
			opnd.value = cdb.data;
		else if (pending[idx])
			opnd.pending = 1'b1;
		return opnd;
	endfunction

	always_comb begin
		operand_a = lookup(rs1);
		operand_b = lookup(rs2);
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int r = 0; r < NUM_REGS; r++) begin
				arch[r] <= '0;
				pending[r] <= 1'b0;
				spec_ready[r] <= 1'b0;
			end
		end else begin
			for (int r = 0; r < NUM_REGS; r++)
				if (bus_hit(r))
					spec_ready[r] <= 1'b1;
			if (commit_valid && (commit_rd != '0)) begin
				arch[commit_rd] <= commit_value;
				// a younger rename keeps the register pending
				if (rat_tag[commit_rd] == commit_tag)
					pending[commit_rd] <= 1'b0;
			end
			// new rename wins over capture and commit in the same cycle
			if (do_rename) begin
				pending[rename_rd] <= 1'b1;
				spec_ready[rename_rd] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int r = 0; r < NUM_REGS; r++)
			if (bus_hit(r))
				spec_value[r] <= cdb.data;
		if (do_rename)
			rat_tag[rename_rd] <= rename_tag;
	end

endmodule

`default_nettype wire

// ==== design/rob_pointers.sv ====
// rob pointers: head, tail and occupancy of the reorder buffer with full and empty
`default_nettype none

module rob_pointers import ooo_pkg::*; (
	input  logic		clk,
	input  logic		reset,
	input  logic		alloc,
	input  logic		commit,
	output rob_tag_t	head,
	output rob_tag_t	tail,
	output logic		full,
	output logic		empty
);

	// one extra bit to tell full from empty
	logic [ROB_TAG_W:0]	count;

	always_ff @(posedge clk) begin
		if (!reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			// pointers wrap at ROB_SIZE
			if (alloc)
				tail <= tail + 1'b1;
			if (commit)
				head <= head + 1'b1;
			case ({alloc, commit})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;
			endcase
		end
	end

	assign full = (count == (ROB_TAG_W + 1)'(ROB_SIZE));
	assign empty = (count == '0);

	// issue and commit both respect occupancy
	a_no_overrun: assert property (@(posedge clk) disable iff (!reset)
		!(alloc && full) && !(commit && empty));

endmodule

`default_nettype wire

// ==== design/issue_control.sv ====
// issue control: four-phase handshake FSM that routes each instruction to a free station
`default_nettype none

module issue_control import ooo_pkg::*; (
	input  logic			clk,
	input  logic			reset,
	input  logic			issue_req,
	output logic			issue_ack,
	input  alu_op_t			issue_op,
	input  reg_idx_t		issue_rd,
	input  data_t			issue_imm,
	input  logic [N_STATIONS-1:0]	station_busy,
	input  logic			rob_full,
	output logic			alloc,
	input  operand_t		operand_a,
	input  operand_t		operand_b,
	dispatch_if.issuer		disp,
	input  rob_tag_t		rob_tail
);

	typedef enum logic [1:0] {IDLE, ISSUE, ACK, WAIT_DROP} state_t;

	state_t			state;
	logic [N_STATIONS-1:0]	free;
	logic [N_STATIONS-1:0]	pick;
	logic			go;

	// lowest free station gets the instruction
	assign free = ~station_busy;
	assign pick = free & (~free + 1'b1);

	// enter only with a station and a reorder-buffer slot available
	assign go = (state == ISSUE) && (|free) && !rob_full;
	assign alloc = go;

	// ack is high from the cycle after entry until req is seen low
	assign issue_ack = (state == ACK);

	always_comb begin
		disp.route = go ? pick : '0;
		disp.op = issue_op;
		disp.operand_a = operand_a;
		disp.dest_tag = rob_tail;
		// addi takes the immediate in place of rs2
		if (issue_op == OP_ADDI)
			disp.operand_b = '{pending: 1'b0, tag: '0, value: issue_imm};
		else
			disp.operand_b = operand_b;
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:		if (issue_req) state <= ISSUE;
				// stall here while resources are busy
				ISSUE:		if (go) state <= ACK;
				ACK:		if (!issue_req) state <= WAIT_DROP;
				// ack is low now, source may start the next req
				WAIT_DROP:	state <= IDLE;
				default:	state <= IDLE;
			endcase
		end
	end

	// at most one station takes an instruction
	a_route_onehot: assert property (@(posedge clk) disable iff (!reset)
		$onehot0(disp.route));

	// ack only answers a req held across the entry
	a_ack_needs_req: assert property (@(posedge clk) disable iff (!reset)
		$rose(issue_ack) |-> issue_req && $past(issue_req));

	// instruction fields hold while issue waits on resources
	a_fields_stable: assert property (@(posedge clk) disable iff (!reset)
		(state == ISSUE) |-> $stable({issue_op, issue_rd, issue_imm}));

endmodule

`default_nettype wire

// ==== design/dispatch_if.sv ====
// dispatch interface: carries one issued instruction from issue control to the stations
`default_nettype none

interface dispatch_if import ooo_pkg::*; ();

	// one-hot target station, all zero when nothing issues
	logic [N_STATIONS-1:0]	route;
	alu_op_t		op;
	// source operands as resolved by the alias table
	operand_t		operand_a;
	operand_t		operand_b;
	// reorder-buffer entry the result belongs to
	rob_tag_t		dest_tag;

	modport issuer (
		output route,
		output op,
		output operand_a,
		output operand_b,
		output dest_tag
	);

	// each station gets its own route bit on a separate port
	modport station (
		input op,
		input operand_a,
		input operand_b,
		input dest_tag
	);

endinterface

`default_nettype wire

// ==== design/ooo_pkg.sv ====
// ooo core package: sizes, opcode and tag types, operand and result bus structs
`default_nettype none

package ooo_pkg;

	// data path width
	localparam int XLEN = 32;

	// architectural register file
	localparam int NUM_REGS = 8;
	localparam int REG_IDX_W = 3;

	// reorder buffer, power of two so the pointers wrap on their own
	localparam int ROB_SIZE = 8;
	localparam int ROB_TAG_W = 3;

	// alu reservation stations, index 0 wins the result bus
	localparam int N_STATIONS = 3;

	typedef logic [XLEN-1:0] data_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	typedef logic [ROB_TAG_W-1:0] rob_tag_t;

	// operations arrive already decoded
	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_AND  = 3'd2,
		OP_OR   = 3'd3,
		OP_XOR  = 3'd4,
		OP_ADDI = 3'd5
	} alu_op_t;

	// source operand, either a value or the tag of its producer
	// tag only counts while pending is set
	typedef struct packed {
		logic		pending;
		rob_tag_t	tag;
		data_t		value;
	} operand_t;

	// common data bus, one result per cycle
	typedef struct packed {
		logic		valid;
		rob_tag_t	tag;
		data_t		data;
	} cdb_t;

endpackage

`default_nettype wire
